// ==== common/dpram_cfg.svh ====
// Scratchpad build options
`ifndef dpram_cfg_svh
`define dpram_cfg_svh

// Width of the AXI data bus in bits. Byte lanes follow from it.
`define dpram_data_width 32

// Width of the byte address. With 32-bit data, 12 bits give 1024 words.
`define dpram_addr_width 12

// Set to 1 for an extra register on each read data path.
`define dpram_pipeline_output 0

`endif

// ==== common/dpram_pkg.sv ====
// Scratchpad shared types
package dpram_pkg;

    // Operation issued to one memory port in a given cycle.
    typedef enum logic [1:0] {
        mem_idle  = 2'b00,
        mem_write = 2'b01,
        mem_read  = 2'b10
    } mem_op_e;

    // AXI response codes. Only okay is ever returned here.
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axil_resp_e;

endpackage

// ==== common/mem_req_if.sv ====
// Memory port request bundle
`timescale 1ns/100ps

`include "dpram_cfg.svh"

interface mem_req_if
    import dpram_pkg::*;
();

    localparam int strb_width      = `dpram_data_width / 8;
    localparam int word_addr_width = `dpram_addr_width - $clog2(strb_width);

    // Valid for a single cycle. The core samples it on the next edge.
    mem_op_e                      op;
    logic [word_addr_width-1:0]   addr;
    logic [`dpram_data_width-1:0] wdata;
    logic [strb_width-1:0]        wstrb;

    modport front (
        output op, addr, wdata, wstrb
    );

    modport core (
        input op, addr, wdata, wstrb
    );

endinterface

// ==== dp_ram/axil_port_front.sv ====
// AXI4-Lite request front end
`timescale 1ns/100ps

`include "dpram_cfg.svh"

module axil_port_front
    import dpram_pkg::*;
(
    input  logic                           a_clk,
    input  logic                           a_rst,

    input  logic [`dpram_addr_width-1:0]   awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [`dpram_data_width-1:0]   wdata,
    input  logic [`dpram_data_width/8-1:0] wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output axil_resp_e                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [`dpram_addr_width-1:0]   araddr,
    input  logic                           arvalid,
    output logic                           arready,

    input  logic                           read_slot_free,
    mem_req_if.front                       mem
);

    localparam int strb_width = `dpram_data_width / 8;
    localparam int addr_lsb   = $clog2(strb_width);

    logic wr_eligible;
    logic rd_eligible;
    logic wr_sel;
    logic rd_sel;
    logic last_write;

    // A request that is being acknowledged this cycle is still on the bus,
    // so it must not be taken a second time.
    assign wr_eligible = awvalid && wvalid && (!bvalid || bready) && !awready && !wready;
    assign rd_eligible = arvalid && read_slot_free && !arready;

    // When both kinds are waiting, serve the one not served last.
    assign wr_sel = wr_eligible && (!rd_eligible || !last_write);
    assign rd_sel = rd_eligible && !wr_sel;

    assign bresp = resp_okay;

    // Request to the core, byte addresses reduced to word addresses.
    always_comb begin
        mem.op    = mem_idle;
        mem.addr  = araddr[`dpram_addr_width-1:addr_lsb];
        mem.wdata = wdata;
        mem.wstrb = '0;
        if (wr_sel) begin
            mem.op    = mem_write;
            mem.addr  = awaddr[`dpram_addr_width-1:addr_lsb];
            mem.wstrb = wstrb;
        end else if (rd_sel) begin
            mem.op = mem_read;
        end
    end

    always_ff @(posedge a_clk) begin
        if (a_rst) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            arready    <= 1'b0;
            bvalid     <= 1'b0;
            // Starting as if a write was last lets the first read win.
            last_write <= 1'b1;
        end else begin
            awready <= wr_sel;
            wready  <= wr_sel;
            arready <= rd_sel;

            if (wr_sel) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (wr_sel) begin
                last_write <= 1'b1;
            end else if (rd_sel) begin
                last_write <= 1'b0;
            end
        end
    end

    // Only one transfer kind is accepted per cycle on a port.
    a_one_accept: assert property (
        @(posedge a_clk) disable iff (a_rst)
        !(awready && arready)
    );

endmodule

// ==== dp_ram/dp_ram_core.sv ====
// Byte-writable dual-port memory array
`timescale 1ns/100ps

`include "dpram_cfg.svh"

module dp_ram_core
    import dpram_pkg::*;
(
    input  logic                         a_clk,
    mem_req_if.core                      port_a,
    mem_req_if.core                      port_b,
    output logic [`dpram_data_width-1:0] rd_data_a,
    output logic                         rd_done_a,
    output logic [`dpram_data_width-1:0] rd_data_b,
    output logic                         rd_done_b
);

    localparam int strb_width      = `dpram_data_width / 8;
    localparam int word_addr_width = `dpram_addr_width - $clog2(strb_width);
    localparam int depth           = 2 ** word_addr_width;

    logic [`dpram_data_width-1:0] mem [depth];

    // Power-up contents for simulation.
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // Port B is applied after port A, so its bytes win on a collision.
    always_ff @(posedge a_clk) begin
        for (int i = 0; i < strb_width; i++) begin
            if (port_a.op == mem_write && port_a.wstrb[i]) begin
                mem[port_a.addr][8*i +: 8] <= port_a.wdata[8*i +: 8];
            end
        end
        for (int i = 0; i < strb_width; i++) begin
            if (port_b.op == mem_write && port_b.wstrb[i]) begin
                mem[port_b.addr][8*i +: 8] <= port_b.wdata[8*i +: 8];
            end
        end
    end

    // Reads see the array before this edge's writes, i.e. old data.
    always_ff @(posedge a_clk) begin
        rd_done_a <= (port_a.op == mem_read);
        rd_done_b <= (port_b.op == mem_read);
        if (port_a.op == mem_read) begin
            rd_data_a <= mem[port_a.addr];
        end
        if (port_b.op == mem_read) begin
            rd_data_b <= mem[port_b.addr];
        end
    end

    // Once the front ends have come out of reset the ops stay known.
    a_op_a_known: assert property (
        @(posedge a_clk) !$isunknown($past(port_a.op)) |-> !$isunknown(port_a.op)
    );
    a_op_b_known: assert property (
        @(posedge a_clk) !$isunknown($past(port_b.op)) |-> !$isunknown(port_b.op)
    );

endmodule

// ==== dp_ram/read_resp_stage.sv ====
// AXI4-Lite read response stage
`timescale 1ns/100ps

`include "dpram_cfg.svh"

module read_resp_stage
    import dpram_pkg::*;
#(
    parameter bit pipeline_output = 1'b0
) (
    input  logic                         a_clk,
    input  logic                         a_rst,
    input  logic [`dpram_data_width-1:0] rd_data,
    input  logic                         rd_done,
    output logic [`dpram_data_width-1:0] rdata,
    output axil_resp_e                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output logic                         read_slot_free
);

    logic word_held;
    logic word_valid;
    logic word_take;

    // The core keeps its read word until the next read, so only the
    // valid bit needs to be held here.
    assign word_valid = rd_done || word_held;
    assign rresp      = resp_okay;

    // A new read is safe when the core word is empty or leaves this edge.
    assign read_slot_free = !word_valid || word_take;

    always_ff @(posedge a_clk) begin
        if (a_rst) begin
            word_held <= 1'b0;
        end else begin
            word_held <= word_valid && !word_take;
        end
    end

    generate
        if (pipeline_output) begin : g_out_reg
            logic                         out_valid;
            logic [`dpram_data_width-1:0] out_data;

            // The output register loads when empty or being accepted.
            assign word_take = !out_valid || rready;
            assign rvalid    = out_valid;
            assign rdata     = out_data;

            always_ff @(posedge a_clk) begin
                if (a_rst) begin
                    out_valid <= 1'b0;
                end else if (word_take) begin
                    out_valid <= word_valid;
                end
            end

            always_ff @(posedge a_clk) begin
                if (word_take) begin
                    out_data <= rd_data;
                end
            end
        end else begin : g_direct
            assign word_take = rready;
            assign rvalid    = word_valid;
            assign rdata     = rd_data;
        end
    endgenerate

    // A stalled response must stay put until the master takes it.
    a_r_stable: assert property (
        @(posedge a_clk) disable iff (a_rst)
        rvalid && !rready |=> rvalid && $stable(rdata)
    );

endmodule

// ==== design/axil_dp_ram_top.sv ====
// AXI4-Lite dual-port scratchpad
`timescale 1ns/100ps

`include "dpram_cfg.svh"

module axil_dp_ram_top (
    input  logic                           a_clk,
    input  logic                           a_rst,

    input  logic [`dpram_addr_width-1:0]   s_axil_a_awaddr,
    input  logic [2:0]                     s_axil_a_awprot,
    input  logic                           s_axil_a_awvalid,
    output logic                           s_axil_a_awready,
    input  logic [`dpram_data_width-1:0]   s_axil_a_wdata,
    input  logic [`dpram_data_width/8-1:0] s_axil_a_wstrb,
    input  logic                           s_axil_a_wvalid,
    output logic                           s_axil_a_wready,
    output logic [1:0]                     s_axil_a_bresp,
    output logic                           s_axil_a_bvalid,
    input  logic                           s_axil_a_bready,
    input  logic [`dpram_addr_width-1:0]   s_axil_a_araddr,
    input  logic [2:0]                     s_axil_a_arprot,
    input  logic                           s_axil_a_arvalid,
    output logic                           s_axil_a_arready,
    output logic [`dpram_data_width-1:0]   s_axil_a_rdata,
    output logic [1:0]                     s_axil_a_rresp,
    output logic                           s_axil_a_rvalid,
    input  logic                           s_axil_a_rready,

    input  logic [`dpram_addr_width-1:0]   s_axil_b_awaddr,
    input  logic [2:0]                     s_axil_b_awprot,
    input  logic                           s_axil_b_awvalid,
    output logic                           s_axil_b_awready,
    input  logic [`dpram_data_width-1:0]   s_axil_b_wdata,
    input  logic [`dpram_data_width/8-1:0] s_axil_b_wstrb,
    input  logic                           s_axil_b_wvalid,
    output logic                           s_axil_b_wready,
    output logic [1:0]                     s_axil_b_bresp,
    output logic                           s_axil_b_bvalid,
    input  logic                           s_axil_b_bready,
    input  logic [`dpram_addr_width-1:0]   s_axil_b_araddr,
    input  logic [2:0]                     s_axil_b_arprot,
    input  logic                           s_axil_b_arvalid,
    output logic                           s_axil_b_arready,
    output logic [`dpram_data_width-1:0]   s_axil_b_rdata,
    output logic [1:0]                     s_axil_b_rresp,
    output logic                           s_axil_b_rvalid,
    input  logic                           s_axil_b_rready
);

    // Protection bits are accepted on both ports but have no effect.

    logic [`dpram_data_width-1:0] rd_data_a;
    logic [`dpram_data_width-1:0] rd_data_b;
    logic                         rd_done_a;
    logic                         rd_done_b;
    logic                         read_slot_free_a;
    logic                         read_slot_free_b;

    mem_req_if mem_a ();
    mem_req_if mem_b ();

    axil_port_front front_a_i (
        .a_clk          (a_clk),
        .a_rst          (a_rst),
        .awaddr         (s_axil_a_awaddr),
        .awvalid        (s_axil_a_awvalid),
        .awready        (s_axil_a_awready),
        .wdata          (s_axil_a_wdata),
        .wstrb          (s_axil_a_wstrb),
        .wvalid         (s_axil_a_wvalid),
        .wready         (s_axil_a_wready),
        .bresp          (s_axil_a_bresp),
        .bvalid         (s_axil_a_bvalid),
        .bready         (s_axil_a_bready),
        .araddr         (s_axil_a_araddr),
        .arvalid        (s_axil_a_arvalid),
        .arready        (s_axil_a_arready),
        .read_slot_free (read_slot_free_a),
        .mem            (mem_a.front)
    );

    axil_port_front front_b_i (
        .a_clk          (a_clk),
        .a_rst          (a_rst),
        .awaddr         (s_axil_b_awaddr),
        .awvalid        (s_axil_b_awvalid),
        .awready        (s_axil_b_awready),
        .wdata          (s_axil_b_wdata),
        .wstrb          (s_axil_b_wstrb),
        .wvalid         (s_axil_b_wvalid),
        .wready         (s_axil_b_wready),
        .bresp          (s_axil_b_bresp),
        .bvalid         (s_axil_b_bvalid),
        .bready         (s_axil_b_bready),
        .araddr         (s_axil_b_araddr),
        .arvalid        (s_axil_b_arvalid),
        .arready        (s_axil_b_arready),
        .read_slot_free (read_slot_free_b),
        .mem            (mem_b.front)
    );

    dp_ram_core core_i (
        .a_clk     (a_clk),
        .port_a    (mem_a.core),
        .port_b    (mem_b.core),
        .rd_data_a (rd_data_a),
        .rd_done_a (rd_done_a),
        .rd_data_b (rd_data_b),
        .rd_done_b (rd_done_b)
    );

    read_resp_stage #(
        .pipeline_output (`dpram_pipeline_output)
    ) resp_a_i (
        .a_clk          (a_clk),
        .a_rst          (a_rst),
        .rd_data        (rd_data_a),
        .rd_done        (rd_done_a),
        .rdata          (s_axil_a_rdata),
        .rresp          (s_axil_a_rresp),
        .rvalid         (s_axil_a_rvalid),
        .rready         (s_axil_a_rready),
        .read_slot_free (read_slot_free_a)
    );

    read_resp_stage #(
        .pipeline_output (`dpram_pipeline_output)
    ) resp_b_i (
        .a_clk          (a_clk),
        .a_rst          (a_rst),
        .rd_data        (rd_data_b),
        .rd_done        (rd_done_b),
        .rdata          (s_axil_b_rdata),
        .rresp          (s_axil_b_rresp),
        .rvalid         (s_axil_b_rvalid),
        .rready         (s_axil_b_rready),
        .read_slot_free (read_slot_free_b)
    );

endmodule

// ==== test/tb_axil_dp_ram.sv ====
// Dual-port scratchpad testbench
`timescale 1ns/100ps

`include "dpram_cfg.svh"

module tb_axil_dp_ram;

    localparam int dw         = `dpram_data_width;
    localparam int aw         = `dpram_addr_width;
    localparam int sw         = dw / 8;
    localparam int lsb        = $clog2(sw);
    localparam int words      = 2 ** (aw - lsb);
    localparam int wait_limit = 50;

    logic          a_clk;
    logic          a_rst;

    // Index 0 is port A, index 1 is port B.
    logic [aw-1:0] awaddr [2];
    logic [1:0]    awvalid;
    logic [dw-1:0] wdata [2];
    logic [sw-1:0] wstrb [2];
    logic [1:0]    wvalid;
    logic [1:0]    bready;
    logic [aw-1:0] araddr [2];
    logic [1:0]    arvalid;
    logic [1:0]    rready;

    wire  [1:0]    awready;
    wire  [1:0]    wready;
    wire  [1:0]    bresp [2];
    wire  [1:0]    bvalid;
    wire  [1:0]    arready;
    wire  [dw-1:0] rdata [2];
    wire  [1:0]    rresp [2];
    wire  [1:0]    rvalid;

    logic [dw-1:0] ref_mem [words];
    int            errors;
    int            tests;
    string         accept_seq;

    axil_dp_ram_top dut_i (
        .a_clk            (a_clk),
        .a_rst            (a_rst),
        .s_axil_a_awaddr  (awaddr[0]),
        .s_axil_a_awprot  (3'b000),
        .s_axil_a_awvalid (awvalid[0]),
        .s_axil_a_awready (awready[0]),
        .s_axil_a_wdata   (wdata[0]),
        .s_axil_a_wstrb   (wstrb[0]),
        .s_axil_a_wvalid  (wvalid[0]),
        .s_axil_a_wready  (wready[0]),
        .s_axil_a_bresp   (bresp[0]),
        .s_axil_a_bvalid  (bvalid[0]),
        .s_axil_a_bready  (bready[0]),
        .s_axil_a_araddr  (araddr[0]),
        .s_axil_a_arprot  (3'b000),
        .s_axil_a_arvalid (arvalid[0]),
        .s_axil_a_arready (arready[0]),
        .s_axil_a_rdata   (rdata[0]),
        .s_axil_a_rresp   (rresp[0]),
        .s_axil_a_rvalid  (rvalid[0]),
        .s_axil_a_rready  (rready[0]),
        .s_axil_b_awaddr  (awaddr[1]),
        .s_axil_b_awprot  (3'b000),
        .s_axil_b_awvalid (awvalid[1]),
        .s_axil_b_awready (awready[1]),
        .s_axil_b_wdata   (wdata[1]),
        .s_axil_b_wstrb   (wstrb[1]),
        .s_axil_b_wvalid  (wvalid[1]),
        .s_axil_b_wready  (wready[1]),
        .s_axil_b_bresp   (bresp[1]),
        .s_axil_b_bvalid  (bvalid[1]),
        .s_axil_b_bready  (bready[1]),
        .s_axil_b_araddr  (araddr[1]),
        .s_axil_b_arprot  (3'b000),
        .s_axil_b_arvalid (arvalid[1]),
        .s_axil_b_arready (arready[1]),
        .s_axil_b_rdata   (rdata[1]),
        .s_axil_b_rresp   (rresp[1]),
        .s_axil_b_rvalid  (rvalid[1]),
        .s_axil_b_rready  (rready[1])
    );

    always begin
        a_clk = 1'b0;
        #2;
        a_clk = 1'b1;
        #2;
    end

    function automatic string pname(int p);
        return (p == 0) ? "s_axil_a_" : "s_axil_b_";
    endfunction

    function automatic void mismatch(string name, logic [dw-1:0] got, logic [dw-1:0] exp);
        errors++;
        $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
    endfunction

    task automatic abort_timeout(string what);
        errors++;
        $display("Timed out waiting for %s", what);
        $display("tests run: %0d, errors: %0d", tests, errors);
        $display("TEST FAILED");
        $finish;
    endtask

    // Reference memory follows the AXI strobe rule, one byte lane per bit.
    function automatic void model_write(logic [aw-1:0] addr, logic [dw-1:0] data,
                                        logic [sw-1:0] strb);
        for (int i = 0; i < sw; i++) begin
            if (strb[i]) begin
                ref_mem[addr[aw-1:lsb]][8*i +: 8] = data[8*i +: 8];
            end
        end
    endfunction

    task automatic check_idle(string when);
        if ((awready | wready | arready | bvalid | rvalid) !== 2'b00) begin
            errors++;
            $display("[FAIL] %s: awready=0x%h wready=0x%h arready=0x%h bvalid=0x%h rvalid=0x%h",
                     when, awready, wready, arready, bvalid, rvalid);
        end
    endtask

    task automatic apply_reset();
        a_rst = 1'b1;
        for (int c = 0; c < 5; c++) begin
            @(posedge a_clk);
            #1;
            check_idle("during reset");
        end
        a_rst = 1'b0;
        @(posedge a_clk);
        #1;
        check_idle("after reset");
    endtask

    // Drives aw and w together and returns one cycle after the accept.
    task automatic write_req(int p, logic [aw-1:0] addr, logic [dw-1:0] data,
                             logic [sw-1:0] strb);
        int n;
        n = 0;
        awaddr[p]  = addr;
        wdata[p]   = data;
        wstrb[p]   = strb;
        awvalid[p] = 1'b1;
        wvalid[p]  = 1'b1;
        while (!awready[p]) begin
            @(posedge a_clk);
            #1;
            n++;
            if (n > wait_limit) abort_timeout({pname(p), "awready"});
        end
        accept_seq = {accept_seq, "W"};
        if (wready[p] !== 1'b1) mismatch({pname(p), "wready"}, dw'(wready[p]), dw'(1));
        if (bvalid[p] !== 1'b1) mismatch({pname(p), "bvalid"}, dw'(bvalid[p]), dw'(1));
        if (bresp[p] !== 2'b00) mismatch({pname(p), "bresp"}, dw'(bresp[p]), dw'(0));
        @(posedge a_clk);
        #1;
        awvalid[p] = 1'b0;
        wvalid[p]  = 1'b0;
    endtask

    task automatic axi_write(int p, logic [aw-1:0] addr, logic [dw-1:0] data,
                             logic [sw-1:0] strb);
        write_req(p, addr, data, strb);
        model_write(addr, data, strb);
    endtask

    task automatic read_req(int p, logic [aw-1:0] addr);
        int n;
        n = 0;
        araddr[p]  = addr;
        arvalid[p] = 1'b1;
        while (!arready[p]) begin
            @(posedge a_clk);
            #1;
            n++;
            if (n > wait_limit) abort_timeout({pname(p), "arready"});
        end
        accept_seq = {accept_seq, "R"};
        @(posedge a_clk);
        #1;
        arvalid[p] = 1'b0;
    endtask

    task automatic wait_rvalid(int p);
        int n;
        n = 0;
        while (!rvalid[p]) begin
            @(posedge a_clk);
            #1;
            n++;
            if (n > wait_limit) abort_timeout({pname(p), "rvalid"});
        end
    endtask

    // Expects rready high, so the transfer happens at the next edge.
    task automatic read_resp(int p, logic [dw-1:0] exp);
        wait_rvalid(p);
        if (rdata[p] !== exp) mismatch({pname(p), "rdata"}, rdata[p], exp);
        if (rresp[p] !== 2'b00) mismatch({pname(p), "rresp"}, dw'(rresp[p]), dw'(0));
        @(posedge a_clk);
        #1;
    endtask

    task automatic axi_read(int p, logic [aw-1:0] addr);
        logic [dw-1:0] exp;
        exp = ref_mem[addr[aw-1:lsb]];
        fork
            read_req(p, addr);
            read_resp(p, exp);
        join
    endtask

    task automatic hold_check(int p, logic [dw-1:0] exp, int cycles);
        for (int c = 0; c < cycles; c++) begin
            if (rvalid[p] !== 1'b1) mismatch({pname(p), "rvalid"}, dw'(rvalid[p]), dw'(1));
            if (rdata[p] !== exp) mismatch({pname(p), "rdata"}, rdata[p], exp);
            @(posedge a_clk);
            #1;
        end
    endtask

    task automatic test_reset_state();
        tests++;
        apply_reset();
    endtask

    task automatic test_shared_storage();
        tests++;
        for (int i = 0; i < 4; i++) begin
            axi_write(0, aw'(12'h040 + 4 * i), dw'($urandom), '1);
        end
        for (int i = 0; i < 4; i++) begin
            axi_read(1, aw'(12'h040 + 4 * i));
            axi_read(0, aw'(12'h040 + 4 * i));
        end
    endtask

    task automatic test_byte_strobes();
        int patterns [5];
        tests++;
        patterns = '{1, 4, 10, 0, 6};
        axi_write(0, aw'(12'h080), dw'($urandom), '1);
        foreach (patterns[k]) begin
            axi_write(k % 2, aw'(12'h080), dw'($urandom), sw'(patterns[k]));
            axi_read(0, aw'(12'h080));
            axi_read(1, aw'(12'h080));
        end
    endtask

    task automatic test_concurrent();
        logic [dw-1:0] d_a;
        logic [dw-1:0] d_b;
        time           t_a;
        time           t_b;
        tests++;
        fork
            for (int i = 0; i < 4; i++) begin
                axi_write(0, aw'(12'h100 + 4 * i), dw'($urandom), '1);
                axi_read(0, aw'(12'h100 + 4 * i));
            end
            for (int i = 0; i < 4; i++) begin
                axi_write(1, aw'(12'h200 + 4 * i), dw'($urandom), '1);
                axi_read(1, aw'(12'h200 + 4 * i));
            end
        join
        axi_read(1, aw'(12'h10c));
        axi_read(0, aw'(12'h20c));

        // Both ports hit one word in the same cycle. Port B wins shared bytes.
        axi_write(0, aw'(12'h2f0), dw'($urandom), '1);
        d_a = dw'($urandom);
        d_b = dw'($urandom);
        fork
            begin
                write_req(0, aw'(12'h2f0), d_a, sw'(3));
                t_a = $time;
            end
            begin
                write_req(1, aw'(12'h2f0), d_b, sw'(6));
                t_b = $time;
            end
        join
        if (t_a != t_b) begin
            errors++;
            $display("Colliding writes on A and B were not accepted in the same cycle");
        end
        model_write(aw'(12'h2f0), d_a, sw'(3));
        model_write(aw'(12'h2f0), d_b, sw'(6));
        axi_read(0, aw'(12'h2f0));
        axi_read(1, aw'(12'h2f0));
    endtask

    task automatic test_read_backpressure();
        logic [dw-1:0] exp1;
        logic [dw-1:0] exp2;
        tests++;
        axi_write(1, aw'(12'h300), dw'($urandom), '1);
        axi_write(1, aw'(12'h304), dw'($urandom), '1);
        exp1 = ref_mem[aw'(12'h300) >> lsb];
        exp2 = ref_mem[aw'(12'h304) >> lsb];
        rready[1] = 1'b0;
        read_req(1, aw'(12'h300));
        wait_rvalid(1);
        hold_check(1, exp1, 10);
        fork
            read_req(1, aw'(12'h304));
            begin
                hold_check(1, exp1, 3);
                rready[1] = 1'b1;
                read_resp(1, exp1);
                read_resp(1, exp2);
            end
        join
    endtask

    task automatic test_alternation();
        tests++;
        apply_reset();
        accept_seq = "";
        fork
            axi_write(0, aw'(12'h3c0), dw'($urandom), '1);
            axi_read(0, aw'(12'h3c4));
        join
        if (accept_seq != "RW") begin
            errors++;
            $display("Accept order after reset was %s, expected RW", accept_seq);
        end
        // A lone read leaves the read as the last served kind, so the write goes first.
        axi_read(0, aw'(12'h3d8));
        accept_seq = "";
        fork
            begin
                axi_write(0, aw'(12'h3c8), dw'($urandom), '1);
                axi_write(0, aw'(12'h3cc), dw'($urandom), '1);
            end
            begin
                axi_read(0, aw'(12'h3d0));
                axi_read(0, aw'(12'h3d4));
            end
        join
        if (accept_seq != "WRWR") begin
            errors++;
            $display("Accept order with queued requests was %s, expected WRWR", accept_seq);
        end
    endtask

    initial begin
        void'($urandom(32'h2a63db55));
        errors = 0;
        tests  = 0;
        a_rst  = 1'b1;
        for (int p = 0; p < 2; p++) begin
            awaddr[p] = '0;
            wdata[p]  = '0;
            wstrb[p]  = '0;
            araddr[p] = '0;
        end
        awvalid = 2'b00;
        wvalid  = 2'b00;
        arvalid = 2'b00;
        bready  = 2'b11;
        rready  = 2'b11;
        for (int i = 0; i < words; i++) begin
            ref_mem[i] = '0;
        end

        test_reset_state();
        test_shared_storage();
        test_byte_strobes();
        test_concurrent();
        test_read_backpressure();
        test_alternation();

        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== axil_dp_ram_top.f ====
+incdir+common
common/dpram_pkg.sv
common/mem_req_if.sv
dp_ram/axil_port_front.sv
dp_ram/dp_ram_core.sv
dp_ram/read_resp_stage.sv
design/axil_dp_ram_top.sv
test/tb_axil_dp_ram.sv

// ==== Makefile ====
TOP := tb_axil_dp_ram

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module axil_dp_ram_top -f axil_dp_ram_top.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f axil_dp_ram_top.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
